//--- common/lsu_config.svh
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Bus widths.
`define LSU_DATA_WIDTH 32
`define LSU_ADDR_WIDTH 32

// SRAM size in words; byte addresses past 4x this are out of range.
`define SRAM_DEPTH_WORDS 256

// Extra cycles before each ready pulse.
`define SRAM_WAIT_CYCLES 1

`endif

//--- common/lsu_pkg.sv
package lsu_pkg;

  // Controller states, one bus transaction at a time.
  typedef enum logic [2:0] {
    idle,
    read_addr,
    read_data,
    write_addr,
    write_data,
    write_resp,
    finish
  } lsu_state_t;

  // Access width requested by the core.
  typedef enum logic [1:0] {
    size_byte,
    size_half,
    size_word
  } mem_size_t;

  // Response codes on the r and b channels.
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_exokay = 2'b01,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } bus_resp_t;

endpackage

//--- lsu/store_align.sv
`timescale 1ns/10ps
`include "lsu_config.svh"

module store_align (
  input  lsu_pkg::mem_size_t               size,
  input  logic [1:0]                       addr_low,
  input  logic [`LSU_DATA_WIDTH-1:0]       store_data,
  output logic [`LSU_DATA_WIDTH-1:0]       wdata,
  output logic [`LSU_DATA_WIDTH/8-1:0]     wstrb
);

  always_comb begin
    case (size)
      lsu_pkg::size_byte: begin
        wdata = store_data << {addr_low, 3'b000};
        wstrb = 4'b0001 << addr_low;
      end
      lsu_pkg::size_half: begin
        wdata = store_data << {addr_low, 3'b000};
        wstrb = 4'b0011 << addr_low;
      end
      default: begin
        // Whole word, all lanes.
        wdata = store_data;
        wstrb = '1;
      end
    endcase
  end

endmodule

//--- lsu/load_extract.sv
`timescale 1ns/10ps
`include "lsu_config.svh"

module load_extract (
  input  lsu_pkg::mem_size_t         size,
  input  logic                       sign_extend,
  input  logic [1:0]                 addr_low,
  input  logic [`LSU_DATA_WIDTH-1:0] rdata,
  output logic [`LSU_DATA_WIDTH-1:0] rdata_ext
);

  logic [`LSU_DATA_WIDTH-1:0] shifted;
  logic                       byte_sign;
  logic                       half_sign;

  // Addressed lanes moved down to bit zero.
  assign shifted = rdata >> {addr_low, 3'b000};

  // Sign bits come from the shifted value.
  assign byte_sign = sign_extend & shifted[7];
  assign half_sign = sign_extend & shifted[15];

  always_comb begin
    case (size)
      lsu_pkg::size_byte: begin
        rdata_ext = {{(`LSU_DATA_WIDTH - 8){byte_sign}}, shifted[7:0]};
      end
      lsu_pkg::size_half: begin
        rdata_ext = {{(`LSU_DATA_WIDTH - 16){half_sign}}, shifted[15:0]};
      end
      default: begin
        rdata_ext = rdata;
      end
    endcase
  end

endmodule

//--- lsu/lsu_control.sv
`timescale 1ns/10ps
`include "lsu_config.svh"

module lsu_control (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       load,
  input  logic                       store,
  input  logic [`LSU_DATA_WIDTH-1:0] rdata_ext,
  input  lsu_pkg::bus_resp_t         rresp,
  input  logic                       arready,
  input  logic                       rvalid,
  input  logic                       awready,
  input  logic                       wready,
  input  lsu_pkg::bus_resp_t         bresp,
  input  logic                       bvalid,
  output logic                       arvalid,
  output logic                       rready,
  output logic                       awvalid,
  output logic                       wvalid,
  output logic                       bready,
  output logic [`LSU_DATA_WIDTH-1:0] load_data,
  output logic                       load_done,
  output logic                       store_done,
  output logic                       bus_error
);

  lsu_pkg::lsu_state_t state;
  logic                is_load;

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= lsu_pkg::idle;
      is_load   <= 1'b0;
      bus_error <= 1'b0;
    end else begin
      case (state)
        lsu_pkg::idle: begin
          // Strobes only count here.
          if (load) begin
            state   <= lsu_pkg::read_addr;
            is_load <= 1'b1;
          end else if (store) begin
            state   <= lsu_pkg::write_addr;
            is_load <= 1'b0;
          end
        end
        lsu_pkg::read_addr: begin
          if (arready) begin
            state <= lsu_pkg::read_data;
          end
        end
        lsu_pkg::read_data: begin
          if (rvalid) begin
            state     <= lsu_pkg::finish;
            bus_error <= (rresp != lsu_pkg::resp_okay);
          end
        end
        lsu_pkg::write_addr: begin
          if (awready) begin
            state <= lsu_pkg::write_data;
          end
        end
        lsu_pkg::write_data: begin
          if (wready) begin
            state <= lsu_pkg::write_resp;
          end
        end
        lsu_pkg::write_resp: begin
          if (bvalid) begin
            state     <= lsu_pkg::finish;
            bus_error <= (bresp != lsu_pkg::resp_okay);
          end
        end
        default: begin
          state <= lsu_pkg::idle;
        end
      endcase
    end
  end

  // Extended word captured on the r handshake.
  always_ff @(posedge clock) begin
    if (state == lsu_pkg::read_data && rvalid) begin
      load_data <= rdata_ext;
    end
  end

  assign arvalid    = (state == lsu_pkg::read_addr);
  assign rready     = (state == lsu_pkg::read_data);
  assign awvalid    = (state == lsu_pkg::write_addr);
  assign wvalid     = (state == lsu_pkg::write_data);
  assign bready     = (state == lsu_pkg::write_resp);
  assign load_done  = (state == lsu_pkg::finish) && is_load;
  assign store_done = (state == lsu_pkg::finish) && !is_load;

  a_one_strobe: assert property (@(posedge clock) disable iff (reset)
    !(load && store))
    else $error("load and store strobes high together");

  a_ar_hold: assert property (@(posedge clock) disable iff (reset)
    arvalid && !arready |=> arvalid)
    else $error("arvalid dropped before arready");

  a_aw_w_order: assert property (@(posedge clock) disable iff (reset)
    !(awvalid && wvalid))
    else $error("awvalid and wvalid high together");

endmodule

//--- source/axi_sram.sv
`timescale 1ns/10ps
`include "lsu_config.svh"

module axi_sram (
  input  logic                         clock,
  input  logic                         reset,
  input  logic [`LSU_ADDR_WIDTH-1:0]   araddr,
  input  logic                         arvalid,
  input  logic                         rready,
  input  logic [`LSU_ADDR_WIDTH-1:0]   awaddr,
  input  logic                         awvalid,
  input  logic [`LSU_DATA_WIDTH-1:0]   wdata,
  input  logic [`LSU_DATA_WIDTH/8-1:0] wstrb,
  input  logic                         wvalid,
  input  logic                         bready,
  output logic                         arready,
  output logic [`LSU_DATA_WIDTH-1:0]   rdata,
  output lsu_pkg::bus_resp_t           rresp,
  output logic                         rvalid,
  output logic                         awready,
  output logic                         wready,
  output lsu_pkg::bus_resp_t           bresp,
  output logic                         bvalid
);

  localparam int wait_cycles = `SRAM_WAIT_CYCLES;
  localparam int count_width = (wait_cycles > 0) ? $clog2(wait_cycles + 1) : 1;
  localparam int index_width = $clog2(`SRAM_DEPTH_WORDS);

  logic [`LSU_DATA_WIDTH-1:0] mem [`SRAM_DEPTH_WORDS];
  logic [2:0]                 chan_valid;
  logic [2:0]                 chan_block;
  logic [2:0]                 chan_ready;
  logic [index_width-1:0]     aw_index;
  logic                       aw_in_range;

  function automatic logic in_range(input logic [`LSU_ADDR_WIDTH-1:0] addr);
    return (addr >> 2) < `SRAM_DEPTH_WORDS;
  endfunction

  // Channel order is ar, aw, w. A channel stalls while its response is pending.
  assign chan_valid = {wvalid, awvalid, arvalid};
  assign chan_block = {bvalid, bvalid, rvalid};

  for (genvar ch = 0; ch < 3; ch++) begin : g_wait
    logic [count_width-1:0] count;
    logic                   ready_q;

    always_ff @(posedge clock) begin
      if (reset) begin
        count   <= '0;
        ready_q <= 1'b0;
      end else if (ready_q) begin
        count   <= '0;
        ready_q <= 1'b0;
      end else if (chan_valid[ch] && !chan_block[ch]) begin
        if (count == count_width'(wait_cycles)) begin
          ready_q <= 1'b1;
        end else begin
          count <= count + count_width'(1);
        end
      end
    end

    assign chan_ready[ch] = ready_q;
  end

  assign arready = chan_ready[0];
  assign awready = chan_ready[1];
  assign wready  = chan_ready[2];

  always_ff @(posedge clock) begin
    if (arvalid && arready) begin
      rdata <= in_range(araddr) ? mem[araddr[index_width+1:2]] : '0;
      rresp <= in_range(araddr) ? lsu_pkg::resp_okay : lsu_pkg::resp_slverr;
    end
    if (awvalid && awready) begin
      aw_index    <= awaddr[index_width+1:2];
      aw_in_range <= in_range(awaddr);
    end
    if (wvalid && wready) begin
      bresp <= aw_in_range ? lsu_pkg::resp_okay : lsu_pkg::resp_slverr;
      for (int lane = 0; lane < `LSU_DATA_WIDTH / 8; lane++) begin
        if (aw_in_range && wstrb[lane]) begin
          mem[aw_index][8*lane +: 8] <= wdata[8*lane +: 8];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rvalid <= 1'b0;
      bvalid <= 1'b0;
    end else begin
      if (arvalid && arready) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
      if (wvalid && wready) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  a_r_hold: assert property (@(posedge clock) disable iff (reset)
    rvalid && !rready |=> rvalid)
    else $error("rvalid dropped before rready");

endmodule

//--- source/lsu_top.sv
`timescale 1ns/10ps
`include "lsu_config.svh"

module lsu_top (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       load,
  input  logic                       store,
  input  lsu_pkg::mem_size_t         size,
  input  logic                       sign_extend,
  input  logic [`LSU_ADDR_WIDTH-1:0] addr,
  input  logic [`LSU_DATA_WIDTH-1:0] store_data,
  output logic [`LSU_DATA_WIDTH-1:0] load_data,
  output logic                       load_done,
  output logic                       store_done,
  output logic                       bus_error
);

  logic [`LSU_DATA_WIDTH-1:0]   rdata;
  logic [`LSU_DATA_WIDTH-1:0]   rdata_ext;
  logic [`LSU_DATA_WIDTH-1:0]   wdata;
  logic [`LSU_DATA_WIDTH/8-1:0] wstrb;
  lsu_pkg::bus_resp_t           rresp;
  lsu_pkg::bus_resp_t           bresp;
  logic                         arvalid;
  logic                         arready;
  logic                         rvalid;
  logic                         rready;
  logic                         awvalid;
  logic                         awready;
  logic                         wvalid;
  logic                         wready;
  logic                         bvalid;
  logic                         bready;

  store_align u_store_align (
    .size       (size),
    .addr_low   (addr[1:0]),
    .store_data (store_data),
    .wdata      (wdata),
    .wstrb      (wstrb)
  );

  load_extract u_load_extract (
    .size        (size),
    .sign_extend (sign_extend),
    .addr_low    (addr[1:0]),
    .rdata       (rdata),
    .rdata_ext   (rdata_ext)
  );

  lsu_control u_control (
    .clock      (clock),
    .reset      (reset),
    .load       (load),
    .store      (store),
    .rdata_ext  (rdata_ext),
    .rresp      (rresp),
    .arready    (arready),
    .rvalid     (rvalid),
    .awready    (awready),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .arvalid    (arvalid),
    .rready     (rready),
    .awvalid    (awvalid),
    .wvalid     (wvalid),
    .bready     (bready),
    .load_data  (load_data),
    .load_done  (load_done),
    .store_done (store_done),
    .bus_error  (bus_error)
  );

  // Core holds addr steady, so it feeds both address channels directly.
  axi_sram u_sram (
    .clock   (clock),
    .reset   (reset),
    .araddr  (addr),
    .arvalid (arvalid),
    .rready  (rready),
    .awaddr  (addr),
    .awvalid (awvalid),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .bready  (bready),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .awready (awready),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid)
  );

endmodule

//--- tb/lsu_tb.sv
`timescale 1ns/10ps
`include "lsu_config.svh"

module lsu_tb;

  localparam int num_rows = 20;
  localparam int lcg_count = 32;
  localparam int done_limit = 100;

  logic                       clock = 1'b0;
  logic                       reset;
  logic                       load;
  logic                       store;
  lsu_pkg::mem_size_t         size;
  logic                       sign_extend;
  logic [`LSU_ADDR_WIDTH-1:0] addr;
  logic [`LSU_DATA_WIDTH-1:0] store_data;
  logic [`LSU_DATA_WIDTH-1:0] load_data;
  logic                       load_done;
  logic                       store_done;
  logic                       bus_error;

  // Stimulus table, one entry per operation.
  logic                       row_store  [num_rows];
  lsu_pkg::mem_size_t         row_size   [num_rows];
  logic                       row_sign   [num_rows];
  logic [`LSU_ADDR_WIDTH-1:0] row_addr   [num_rows];
  logic [`LSU_DATA_WIDTH-1:0] row_data   [num_rows];
  logic [`LSU_DATA_WIDTH-1:0] row_expect [num_rows];
  lsu_pkg::bus_resp_t         row_resp   [num_rows];

  logic [`LSU_DATA_WIDTH-1:0] shadow [`SRAM_DEPTH_WORDS];
  bit                         used   [`SRAM_DEPTH_WORDS];
  int                         picked [lcg_count];

  int error_count = 0;
  int timeout_count = 0;
  int load_ops = 0;
  int store_ops = 0;
  int load_pulses = 0;
  int store_pulses = 0;

  lsu_top dut_i (
    .clock       (clock),
    .reset       (reset),
    .load        (load),
    .store       (store),
    .size        (size),
    .sign_extend (sign_extend),
    .addr        (addr),
    .store_data  (store_data),
    .load_data   (load_data),
    .load_done   (load_done),
    .store_done  (store_done),
    .bus_error   (bus_error)
  );

  always #4 clock = ~clock;

  // Done pulses counted mid-cycle.
  always @(negedge clock) begin
    if (!reset) begin
      if (load_done) load_pulses++;
      if (store_done) store_pulses++;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] value);
    return value * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_word(input logic [`LSU_DATA_WIDTH-1:0] expected,
                            input logic [`LSU_DATA_WIDTH-1:0] actual, input string tag);
    if (actual !== expected) begin
      error_count++;
      $display("[FAIL] %0t: %s load data %h, expected %h", $time, tag, actual, expected);
    end
  endtask

  task automatic check_resp(input lsu_pkg::bus_resp_t expected, input logic error_flag,
                            input string tag);
    if ((expected != lsu_pkg::resp_okay) !== error_flag) begin
      error_count++;
      $display("[FAIL] %0t: %s bus_error %b, expected response %s", $time, tag,
               error_flag, expected.name());
    end
  endtask

  task automatic check_done_kind(input logic exp_store, input logic seen_load,
                                 input logic seen_store, input string tag);
    if (seen_store !== exp_store || seen_load !== !exp_store) begin
      error_count++;
      $display("[FAIL] %0t: %s done pulses load %b store %b, expected %s", $time, tag,
               seen_load, seen_store, exp_store ? "store" : "load");
    end
  endtask

  task automatic set_row(input int i, input logic is_store, input lsu_pkg::mem_size_t sz,
                         input logic sx, input logic [31:0] a, input logic [31:0] d,
                         input logic [31:0] expected, input lsu_pkg::bus_resp_t resp);
    row_store[i]  = is_store;
    row_size[i]   = sz;
    row_sign[i]   = sx;
    row_addr[i]   = a;
    row_data[i]   = d;
    row_expect[i] = expected;
    row_resp[i]   = resp;
  endtask

  task automatic fill_table();
    set_row(0, 1, lsu_pkg::size_word, 0, 32'h010, 32'hdeadbeef, 0, lsu_pkg::resp_okay);
    set_row(1, 0, lsu_pkg::size_word, 0, 32'h010, 0, 32'hdeadbeef, lsu_pkg::resp_okay);
    // Byte stores with junk in the upper bits of store_data.
    set_row(2, 1, lsu_pkg::size_byte, 0, 32'h020, 32'hffffff11, 0, lsu_pkg::resp_okay);
    set_row(3, 1, lsu_pkg::size_byte, 0, 32'h021, 32'hffffff22, 0, lsu_pkg::resp_okay);
    set_row(4, 1, lsu_pkg::size_byte, 0, 32'h022, 32'h00000083, 0, lsu_pkg::resp_okay);
    set_row(5, 1, lsu_pkg::size_byte, 0, 32'h023, 32'habcdeff4, 0, lsu_pkg::resp_okay);
    set_row(6, 0, lsu_pkg::size_word, 0, 32'h020, 0, 32'hf4832211, lsu_pkg::resp_okay);
    set_row(7, 0, lsu_pkg::size_byte, 1, 32'h022, 0, 32'hffffff83, lsu_pkg::resp_okay);
    set_row(8, 0, lsu_pkg::size_byte, 0, 32'h022, 0, 32'h00000083, lsu_pkg::resp_okay);
    set_row(9, 0, lsu_pkg::size_byte, 1, 32'h021, 0, 32'h00000022, lsu_pkg::resp_okay);
    set_row(10, 0, lsu_pkg::size_byte, 1, 32'h023, 0, 32'hfffffff4, lsu_pkg::resp_okay);
    set_row(11, 0, lsu_pkg::size_half, 1, 32'h022, 0, 32'hfffff483, lsu_pkg::resp_okay);
    set_row(12, 0, lsu_pkg::size_half, 0, 32'h022, 0, 32'h0000f483, lsu_pkg::resp_okay);
    set_row(13, 0, lsu_pkg::size_half, 1, 32'h020, 0, 32'h00002211, lsu_pkg::resp_okay);
    set_row(14, 1, lsu_pkg::size_half, 0, 32'h012, 32'h12348001, 0, lsu_pkg::resp_okay);
    set_row(15, 0, lsu_pkg::size_word, 0, 32'h010, 0, 32'h8001beef, lsu_pkg::resp_okay);
    set_row(16, 0, lsu_pkg::size_half, 1, 32'h012, 0, 32'hffff8001, lsu_pkg::resp_okay);
    // Out of range; 0x410 aliases word 0x010 in the index bits.
    set_row(17, 1, lsu_pkg::size_word, 0, `SRAM_DEPTH_WORDS * 4 + 32'h10, 32'h12345678, 0,
            lsu_pkg::resp_slverr);
    set_row(18, 0, lsu_pkg::size_word, 0, 32'hfffffff0, 0, 0, lsu_pkg::resp_slverr);
    set_row(19, 0, lsu_pkg::size_word, 0, 32'h010, 0, 32'h8001beef, lsu_pkg::resp_okay);
  endtask

  // One transaction, with a second strobe while busy.
  task automatic run_op(input logic is_store, input lsu_pkg::mem_size_t op_size,
                        input logic op_sign, input logic [31:0] op_addr,
                        input logic [31:0] op_data, input string tag,
                        output logic [31:0] got_data, output logic got_error);
    logic seen_load;
    logic seen_store;
    logic done;
    done        = 1'b0;
    seen_load   = 1'b0;
    seen_store  = 1'b0;
    got_data    = '0;
    got_error   = 1'b0;
    size        = op_size;
    sign_extend = op_sign;
    addr        = op_addr;
    store_data  = op_data;
    load        = !is_store;
    store       = is_store;
    @(posedge clock);
    #1;
    load  = 1'b0;
    store = 1'b0;
    for (int cycle = 0; cycle < done_limit && !done; cycle++) begin
      @(posedge clock);
      #1;
      load  = 1'b0;
      store = 1'b0;
      if (load_done || store_done) begin
        done       = 1'b1;
        seen_load  = load_done;
        seen_store = store_done;
        got_data   = load_data;
        got_error  = bus_error;
      end else if (cycle == 0) begin
        load  = !is_store;
        store = is_store;
      end
    end
    if (is_store) store_ops++;
    else load_ops++;
    if (!done) begin
      timeout_count++;
      $display("Timeout: %s got no done pulse within %0d cycles", tag, done_limit);
    end else begin
      check_done_kind(is_store, seen_load, seen_store, tag);
    end
    // Back to idle before the next strobe.
    @(posedge clock);
    #1;
  endtask

  initial begin
    logic [31:0] lcg_state;
    logic [31:0] got_data;
    logic        got_error;
    int          index;
    int          tries;
    reset       = 1'b1;
    load        = 1'b0;
    store       = 1'b0;
    size        = lsu_pkg::size_word;
    sign_extend = 1'b0;
    addr        = '0;
    store_data  = '0;
    lcg_state   = 32'hd5e7_45be;
    fill_table();
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;

    for (int i = 0; i < num_rows; i++) begin
      run_op(row_store[i], row_size[i], row_sign[i], row_addr[i], row_data[i],
             $sformatf("row %0d", i), got_data, got_error);
      if (!row_store[i]) check_word(row_expect[i], got_data, $sformatf("row %0d", i));
      check_resp(row_resp[i], got_error, $sformatf("row %0d", i));
    end

    // Random word writes to distinct addresses.
    for (int n = 0; n < lcg_count; n++) begin
      tries = 0;
      index = 0;
      do begin
        lcg_state = lcg_next(lcg_state);
        index     = int'(lcg_state[23:8]) % `SRAM_DEPTH_WORDS;
        tries++;
      end while (used[index] && tries < 1000);
      used[index] = 1'b1;
      picked[n]   = index;
      lcg_state   = lcg_next(lcg_state);
      shadow[index] = lcg_state;
      run_op(1'b1, lsu_pkg::size_word, 1'b0, index << 2, lcg_state,
             $sformatf("random write %0d", n), got_data, got_error);
      check_resp(lsu_pkg::resp_okay, got_error, $sformatf("random write %0d", n));
    end
    for (int n = 0; n < lcg_count; n++) begin
      run_op(1'b0, lsu_pkg::size_word, 1'b0, picked[n] << 2, '0,
             $sformatf("read-back %0d", n), got_data, got_error);
      check_word(shadow[picked[n]], got_data, $sformatf("read-back %0d", n));
      check_resp(lsu_pkg::resp_okay, got_error, $sformatf("read-back %0d", n));
    end

    // Quiet window for any late done pulse.
    for (int cycle = 0; cycle < 20; cycle++) begin
      @(posedge clock);
    end
    if (load_pulses != load_ops || store_pulses != store_ops) begin
      error_count++;
      $display("[FAIL] %0t: done pulses load %0d store %0d, expected %0d and %0d", $time,
               load_pulses, store_pulses, load_ops, store_ops);
    end
    $display("Summary: %0d value errors, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+common
common/lsu_pkg.sv
lsu/store_align.sv
lsu/load_extract.sv
lsu/lsu_control.sv
source/axi_sram.sv
source/lsu_top.sv
tb/lsu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

PASS_TEXT := ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
